// File: Bender.yml
package:
  name: icache

sources:
  - common/icache_cfg_pkg.sv
  - common/icache_ctl_pkg.sv
  - common/line_wr_if.sv
  - icache/icache_bank.sv
  - icache/icache_refill.sv
  - icache/icache_align.sv
  - rtl/icache_top.sv
  - target: simulation
    files:
      - sim/icache_assert.sv
      - sim/icache_tb.sv

// File: common/icache_cfg_pkg.sv
// Geometry of the two-bank instruction cache and the address, tag and line
// types built on it. Every RTL file and the testbench refer to these through
// scoped names.

package icache_cfg_pkg;

	// =========================================================================
	// Geometry
	// =========================================================================

	// Byte address width of the fetch path
	localparam int ADR_W = 32;
	// Byte offset bits inside one 16-byte line
	localparam int OFS_W = 4;
	// Set index bits per bank, taken from address bits 7:5
	localparam int SET_W = 3;
	// Number of sets in one bank
	localparam int SETS = 1 << SET_W;
	// Ways per bank
	localparam int WAYS = 2;
	// Line width in bits, four 32-bit words
	localparam int LINE_W = 128;
	// Tag width, taken from address bits 31:8
	localparam int TAG_W = ADR_W - OFS_W - SET_W - 1;

	// =========================================================================
	// Types
	// =========================================================================

	typedef logic [ADR_W-1:0] adr_t;
	// A line address drops the byte offset, bit 0 of it is the bank parity
	typedef logic [ADR_W-OFS_W-1:0] line_adr_t;
	typedef logic [TAG_W-1:0] tag_t;
	typedef logic [SET_W-1:0] set_t;
	typedef logic [$clog2(WAYS)-1:0] way_t;
	// Word k of a line sits in element k
	typedef logic [LINE_W/32-1:0][31:0] line_t;

endpackage

// File: common/icache_ctl_pkg.sv
// Control encodings for the instruction cache. Invalidation requests come
// in from the top level, refill sequencing lives in the refill controller.

package icache_ctl_pkg;

	// Invalidation request seen by both banks at the same edge
	typedef enum logic [1:0] {
		INV_NONE = 2'd0,
		INV_LINE = 2'd1,
		INV_ALL  = 2'd2
	} inv_op_e;

	// Refill controller states, one per phase pair of the req/ack exchange
	typedef enum logic [1:0] {
		RF_IDLE     = 2'd0,
		RF_REQ      = 2'd1,
		RF_WAIT_LOW = 2'd2
	} refill_state_e;

endpackage

// File: common/line_wr_if.sv
// Line write path from the refill controller into one cache bank.
// The bank stores tag and data and sets the valid bit on the edge where wr
// is high. One instance is used per bank.

`timescale 1ns/100ps

interface line_wr_if;

	// Write strobe, high for exactly one cycle per refilled line
	logic wr;
	// Line address, supplies both the set index and the tag
	icache_cfg_pkg::line_adr_t adr;
	// Way chosen by the round-robin pointer of this bank
	icache_cfg_pkg::way_t way;
	icache_cfg_pkg::line_t data;

	// Refill controller side
	modport src (output wr, adr, way, data);
	// Bank side
	modport dst (input wr, adr, way, data);

endinterface

// File: icache/icache_align.sv
// Output stage of the instruction cache. It orders the even and odd bank
// results into the lo and hi lines of the registered fetch address, combines
// the hits and names the first missing line for refill.

`timescale 1ns/100ps

module icache_align (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      fetch_v_i,
	input  icache_cfg_pkg::adr_t      fetch_adr_i,
	input  logic                      even_hit_i,
	input  logic                      odd_hit_i,
	input  icache_cfg_pkg::line_t     even_data_i,
	input  icache_cfg_pkg::line_t     odd_data_i,
	output logic                      valid_o,
	output logic                      hit_o,
	output icache_cfg_pkg::adr_t      adr_o,
	output icache_cfg_pkg::line_t     line_lo_o,
	output icache_cfg_pkg::line_t     line_hi_o,
	output logic                      miss_v_o,
	output icache_cfg_pkg::line_adr_t miss_adr_o
);

	logic                      v_q;
	icache_cfg_pkg::adr_t      adr_q;
	icache_cfg_pkg::line_adr_t lo_line;
	// Parity of the lo line, when set the odd bank holds lo
	logic                      lo_odd;
	logic                      lo_hit;
	logic                      hi_hit;

	// Fetch request lines up with the one-cycle bank read
	always_ff @(posedge clk) begin
		if (rst)
			v_q <= 1'b0;
		else
			v_q <= fetch_v_i;
	end

	always_ff @(posedge clk)
		adr_q <= fetch_adr_i;

	assign lo_line = adr_q[icache_cfg_pkg::ADR_W-1:icache_cfg_pkg::OFS_W];
	assign lo_odd  = lo_line[0];
	assign lo_hit  = lo_odd ? odd_hit_i : even_hit_i;
	assign hi_hit  = lo_odd ? even_hit_i : odd_hit_i;

	assign valid_o   = v_q;
	assign adr_o     = adr_q;
	assign line_lo_o = lo_odd ? odd_data_i : even_data_i;
	assign line_hi_o = lo_odd ? even_data_i : odd_data_i;
	// A fetch may cross into the hi line, so both lines have to be present
	assign hit_o     = v_q && lo_hit && hi_hit;

	// Lo line is refilled first, the hi line is asked for once lo hits
	assign miss_v_o   = v_q && !(lo_hit && hi_hit);
	assign miss_adr_o = lo_hit ? lo_line + 1'b1 : lo_line;

endmodule

// File: icache/icache_bank.sv
// One parity bank of the instruction cache, two-way set-associative.
// ODD selects whether the bank holds even or odd line addresses. Lookup
// results appear one cycle after the fetch address is sampled.

`timescale 1ns/100ps

module icache_bank #(
	parameter bit ODD = 1'b0
) (
	input  logic                    clk,
	input  logic                    rst,
	input  icache_cfg_pkg::adr_t    fetch_adr_i,
	input  icache_ctl_pkg::inv_op_e inv_op_i,
	input  icache_cfg_pkg::adr_t    inv_adr_i,
	line_wr_if.dst                  wr,
	output logic                    hit_o,
	output icache_cfg_pkg::line_t   data_o
);

	// Tag, data and valid bit of every way at every set
	icache_cfg_pkg::tag_t  tag_mem  [icache_cfg_pkg::WAYS][icache_cfg_pkg::SETS];
	icache_cfg_pkg::line_t data_mem [icache_cfg_pkg::WAYS][icache_cfg_pkg::SETS];
	logic [icache_cfg_pkg::WAYS-1:0][icache_cfg_pkg::SETS-1:0] valid_q;

	// Lookup side
	icache_cfg_pkg::line_adr_t fetch_line;
	icache_cfg_pkg::line_adr_t bank_line;
	icache_cfg_pkg::set_t      rd_set;
	icache_cfg_pkg::tag_t      lk_tag_q;
	icache_cfg_pkg::tag_t      rd_tag_q   [icache_cfg_pkg::WAYS];
	icache_cfg_pkg::line_t     rd_data_q  [icache_cfg_pkg::WAYS];
	logic [icache_cfg_pkg::WAYS-1:0] rd_valid_q;

	// Write side
	icache_cfg_pkg::set_t wr_set;
	icache_cfg_pkg::set_t inv_set;

	// The lo line is the one holding the fetch address. When its parity is
	// not ours, this bank serves the hi line, which is the next line up
	assign fetch_line = fetch_adr_i[icache_cfg_pkg::ADR_W-1:icache_cfg_pkg::OFS_W];
	assign bank_line  = fetch_line + icache_cfg_pkg::line_adr_t'(fetch_line[0] ^ ODD);
	// Bit 0 of a line address is the parity, the set index sits just above
	assign rd_set  = bank_line[icache_cfg_pkg::SET_W:1];
	assign wr_set  = wr.adr[icache_cfg_pkg::SET_W:1];
	assign inv_set = inv_adr_i[icache_cfg_pkg::OFS_W+icache_cfg_pkg::SET_W:
		icache_cfg_pkg::OFS_W+1];

	// =========================================================================
	// Storage
	// =========================================================================

	// Refill writes the tag and the line into the chosen way
	always_ff @(posedge clk) begin
		if (wr.wr) begin
			tag_mem[wr.way][wr_set]  <= wr.adr[icache_cfg_pkg::ADR_W-icache_cfg_pkg::OFS_W-1:
				icache_cfg_pkg::SET_W+1];
			data_mem[wr.way][wr_set] <= wr.data;
		end
	end

	// The write is placed last so that it wins over an invalidation at the same edge
	always_ff @(posedge clk) begin
		if (rst) begin
			valid_q <= '0;
		end else begin
			if (inv_op_i == icache_ctl_pkg::INV_ALL) begin
				valid_q <= '0;
			end else if (inv_op_i == icache_ctl_pkg::INV_LINE &&
				inv_adr_i[icache_cfg_pkg::OFS_W] == ODD) begin
				for (int w = 0; w < icache_cfg_pkg::WAYS; w++)
					valid_q[w][inv_set] <= 1'b0;
			end
			if (wr.wr)
				valid_q[wr.way][wr_set] <= 1'b1;
		end
	end

	// =========================================================================
	// Lookup
	// =========================================================================

	// Every way at the set is read, and a same-edge write is not yet seen
	always_ff @(posedge clk) begin
		lk_tag_q <= bank_line[icache_cfg_pkg::ADR_W-icache_cfg_pkg::OFS_W-1:
			icache_cfg_pkg::SET_W+1];
		for (int w = 0; w < icache_cfg_pkg::WAYS; w++) begin
			rd_tag_q[w]  <= tag_mem[w][rd_set];
			rd_data_q[w] <= data_mem[w][rd_set];
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			rd_valid_q <= '0;
		end else begin
			for (int w = 0; w < icache_cfg_pkg::WAYS; w++)
				rd_valid_q[w] <= valid_q[w][rd_set];
		end
	end

	// At most one way matches, since refill only writes a line that missed
	always_comb begin
		hit_o  = 1'b0;
		data_o = rd_data_q[0];
		for (int w = 0; w < icache_cfg_pkg::WAYS; w++) begin
			if (rd_valid_q[w] && rd_tag_q[w] == lk_tag_q) begin
				hit_o  = 1'b1;
				data_o = rd_data_q[w];
			end
		end
	end

endmodule

// File: icache/icache_refill.sv
// Refill controller of the instruction cache. It takes one miss at a time,
// runs the four-phase req/ack exchange with the memory side and writes the
// returned line into the bank of matching parity.

`timescale 1ns/100ps

module icache_refill (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      miss_v_i,
	input  icache_cfg_pkg::line_adr_t miss_adr_i,
	line_wr_if.src                    even_wr,
	line_wr_if.src                    odd_wr,
	output logic                      refill_req_o,
	output icache_cfg_pkg::line_adr_t refill_adr_o,
	input  logic                      refill_ack_i,
	input  icache_cfg_pkg::line_t     refill_data_i
);

	icache_ctl_pkg::refill_state_e state_q;
	icache_ctl_pkg::refill_state_e state_d;

	// Line being fetched, held stable while req is up
	icache_cfg_pkg::line_adr_t adr_q;
	// Round-robin way pointers, element 0 for the even bank and 1 for the odd
	icache_cfg_pkg::way_t [1:0] way_ptr_q;
	// High on the cycle whose closing edge samples ack high
	logic fill;

	// =========================================================================
	// Handshake FSM
	// =========================================================================

	always_comb begin
		state_d = state_q;
		case (state_q)
			// Misses are only taken here, anything arriving later is dropped
			icache_ctl_pkg::RF_IDLE:
				if (miss_v_i)
					state_d = icache_ctl_pkg::RF_REQ;
			icache_ctl_pkg::RF_REQ:
				if (refill_ack_i)
					state_d = icache_ctl_pkg::RF_WAIT_LOW;
			// req may only come back after ack has been seen low
			icache_ctl_pkg::RF_WAIT_LOW:
				if (!refill_ack_i)
					state_d = icache_ctl_pkg::RF_IDLE;
			default:
				state_d = icache_ctl_pkg::RF_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst)
			state_q <= icache_ctl_pkg::RF_IDLE;
		else
			state_q <= state_d;
	end

	always_ff @(posedge clk) begin
		if (state_q == icache_ctl_pkg::RF_IDLE && miss_v_i)
			adr_q <= miss_adr_i;
	end

	assign fill         = (state_q == icache_ctl_pkg::RF_REQ) && refill_ack_i;
	assign refill_req_o = (state_q == icache_ctl_pkg::RF_REQ);
	assign refill_adr_o = adr_q;

	// =========================================================================
	// Bank writes
	// =========================================================================

	// Parity bit of the line address picks the bank
	assign even_wr.wr   = fill && !adr_q[0];
	assign even_wr.adr  = adr_q;
	assign even_wr.way  = way_ptr_q[0];
	assign even_wr.data = refill_data_i;

	assign odd_wr.wr    = fill && adr_q[0];
	assign odd_wr.adr   = adr_q;
	assign odd_wr.way   = way_ptr_q[1];
	assign odd_wr.data  = refill_data_i;

	// Only the pointer of the bank just written moves on
	always_ff @(posedge clk) begin
		if (rst)
			way_ptr_q <= '0;
		else if (fill)
			way_ptr_q[adr_q[0]] <= ~way_ptr_q[adr_q[0]];
	end

endmodule

// File: list.f
common/icache_cfg_pkg.sv
common/icache_ctl_pkg.sv
common/line_wr_if.sv
icache/icache_bank.sv
icache/icache_refill.sv
icache/icache_align.sv
rtl/icache_top.sv
sim/icache_assert.sv
sim/icache_tb.sv

// File: rtl/icache_top.sv
// Two-bank instruction cache for the fetch unit. One lookup returns the line
// holding the fetch address and the line after it, one cycle later. Missing
// lines are fetched from outside over a four-phase req/ack exchange.

`timescale 1ns/100ps

module icache_top (
	input  logic                          clk,
	input  logic                          rst,
	input  logic                          fetch_v_i,
	input  icache_cfg_pkg::adr_t          fetch_adr_i,
	input  icache_ctl_pkg::inv_op_e       inv_op_i,
	input  icache_cfg_pkg::adr_t          inv_adr_i,
	output logic                          valid_o,
	output logic                          hit_o,
	output icache_cfg_pkg::adr_t          adr_o,
	output icache_cfg_pkg::line_t         line_lo_o,
	output icache_cfg_pkg::line_t         line_hi_o,
	output logic                          refill_req_o,
	output icache_cfg_pkg::line_adr_t     refill_adr_o,
	input  logic                          refill_ack_i,
	input  icache_cfg_pkg::line_t         refill_data_i
);

	// Bank results, valid one cycle after the lookup edge
	logic                  even_hit;
	logic                  odd_hit;
	icache_cfg_pkg::line_t even_data;
	icache_cfg_pkg::line_t odd_data;

	// Miss request from the output stage to the refill controller
	logic                      miss_v;
	icache_cfg_pkg::line_adr_t miss_adr;

	// One write path per bank
	line_wr_if even_wr_if ();
	line_wr_if odd_wr_if ();

	// =========================================================================
	// Banks
	// =========================================================================

	icache_bank #(.ODD(1'b0)) i_even_bank (
		.clk         (clk),
		.rst         (rst),
		.fetch_adr_i (fetch_adr_i),
		.inv_op_i    (inv_op_i),
		.inv_adr_i   (inv_adr_i),
		.wr          (even_wr_if.dst),
		.hit_o       (even_hit),
		.data_o      (even_data)
	);

	icache_bank #(.ODD(1'b1)) i_odd_bank (
		.clk         (clk),
		.rst         (rst),
		.fetch_adr_i (fetch_adr_i),
		.inv_op_i    (inv_op_i),
		.inv_adr_i   (inv_adr_i),
		.wr          (odd_wr_if.dst),
		.hit_o       (odd_hit),
		.data_o      (odd_data)
	);

	// =========================================================================
	// Output ordering and refill
	// =========================================================================

	icache_align i_align (
		.clk         (clk),
		.rst         (rst),
		.fetch_v_i   (fetch_v_i),
		.fetch_adr_i (fetch_adr_i),
		.even_hit_i  (even_hit),
		.odd_hit_i   (odd_hit),
		.even_data_i (even_data),
		.odd_data_i  (odd_data),
		.valid_o     (valid_o),
		.hit_o       (hit_o),
		.adr_o       (adr_o),
		.line_lo_o   (line_lo_o),
		.line_hi_o   (line_hi_o),
		.miss_v_o    (miss_v),
		.miss_adr_o  (miss_adr)
	);

	icache_refill i_refill (
		.clk           (clk),
		.rst           (rst),
		.miss_v_i      (miss_v),
		.miss_adr_i    (miss_adr),
		.even_wr       (even_wr_if.src),
		.odd_wr        (odd_wr_if.src),
		.refill_req_o  (refill_req_o),
		.refill_adr_o  (refill_adr_o),
		.refill_ack_i  (refill_ack_i),
		.refill_data_i (refill_data_i)
	);

endmodule

// File: sim/icache_assert.sv
// Concurrent checks on the refill req/ack exchange and the bank write strobes.
// Bound into every icache_refill instance.

`timescale 1ns/100ps

module icache_assert (
	input logic clk,
	input logic rst,
	input logic req_i,
	input logic ack_i,
	input logic even_wr_i,
	input logic odd_wr_i
);

	// A request is held until the responder acknowledges it
	req_held: assert property (@(posedge clk) disable iff (rst)
		req_i && !ack_i |=> req_i)
		else $error("refill req dropped before ack was seen");

	// While ack is still up from the last exchange, req has to stay down
	req_no_rise: assert property (@(posedge clk) disable iff (rst)
		!req_i && ack_i |=> !req_i)
		else $error("refill req rose while ack was high");

	// Only the bank of matching parity is written
	wr_one_bank: assert property (@(posedge clk) disable iff (rst)
		!(even_wr_i && odd_wr_i))
		else $error("both banks written on the same edge");

	// req has to be low once a reset edge was seen
	req_in_reset: assert property (@(posedge clk) rst |=> !req_i)
		else $error("refill req high after a reset edge");

endmodule

bind icache_refill icache_assert i_assert (
	.clk       (clk),
	.rst       (rst),
	.req_i     (refill_req_o),
	.ack_i     (refill_ack_i),
	.even_wr_i (even_wr.wr),
	.odd_wr_i  (odd_wr.wr)
);

// File: sim/icache_tb.sv
// Testbench for the two-bank instruction cache. LFSR stimulus drives fetches
// and invalidations, a memory responder answers refills, and a reference
// model of tags, valid bits and way pointers predicts every lookup.

`timescale 1ns/100ps

module icache_tb;

	// Three stimulus phases plus reset and drain, each well under 800 cycles
	localparam int PHASE_CYCLES   = 700;
	localparam int TIMEOUT_CYCLES = 4 * 800;
	localparam int MODE_SPREAD    = 0;
	localparam int MODE_CONFLICT  = 1;
	localparam int MODE_INV       = 2;
	localparam int MODE_IDLE      = 3;
	localparam icache_cfg_pkg::adr_t WIN_BASE = 32'h0004_0000;

	logic                          clk;
	logic                          rst;
	logic                          fetch_v;
	icache_cfg_pkg::adr_t          fetch_adr;
	icache_ctl_pkg::inv_op_e       inv_op;
	icache_cfg_pkg::adr_t          inv_adr;
	logic                          valid;
	logic                          hit;
	icache_cfg_pkg::adr_t          adr;
	icache_cfg_pkg::line_t         line_lo;
	icache_cfg_pkg::line_t         line_hi;
	logic                          refill_req;
	icache_cfg_pkg::line_adr_t     refill_adr;
	logic                          refill_ack;
	icache_cfg_pkg::line_t         refill_data;

	// Reference model, indexed by bank parity, way and set
	bit                   m_valid [2][icache_cfg_pkg::WAYS][icache_cfg_pkg::SETS];
	icache_cfg_pkg::tag_t m_tag   [2][icache_cfg_pkg::WAYS][icache_cfg_pkg::SETS];
	bit                   m_ptr   [2];
	icache_ctl_pkg::refill_state_e m_state;
	icache_cfg_pkg::line_adr_t     m_adr;
	// Miss visible before the next edge, and the inputs sampled at that edge
	bit                        pend_miss_v;
	icache_cfg_pkg::line_adr_t pend_miss_adr;
	bit                        p_fetch_v;
	icache_cfg_pkg::adr_t      p_fetch_adr;
	icache_ctl_pkg::inv_op_e   p_inv_op;
	icache_cfg_pkg::adr_t      p_inv_adr;
	bit                        p_ack;

	logic [31:0] lfsr_q;
	int          resp_wait;
	int          errors;
	int          hits;
	int          misses;
	int          refills;
	int          cycle_cnt;
	string       cur_test;

	icache_top i_dut (
		.clk           (clk),
		.rst           (rst),
		.fetch_v_i     (fetch_v),
		.fetch_adr_i   (fetch_adr),
		.inv_op_i      (inv_op),
		.inv_adr_i     (inv_adr),
		.valid_o       (valid),
		.hit_o         (hit),
		.adr_o         (adr),
		.line_lo_o     (line_lo),
		.line_hi_o     (line_hi),
		.refill_req_o  (refill_req),
		.refill_adr_o  (refill_adr),
		.refill_ack_i  (refill_ack),
		.refill_data_i (refill_data)
	);

	always #10 clk = ~clk;

	// Ends the run once the cycle limit is reached
	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYCLES) begin
			$display("Timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("Regression failed");
			$finish;
		end
	end

	// =========================================================================
	// Random numbers and memory contents
	// =========================================================================

	// Fibonacci LFSR with taps 32, 22, 2 and 1
	function automatic logic [31:0] lfsr_next(logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [31:0] take_bits(int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_q = lfsr_next(lfsr_q);
			v = {v[30:0], lfsr_q[0]};
		end
		return v;
	endfunction

	// Word k of line L holds its own byte address
	function automatic icache_cfg_pkg::line_t line_contents(icache_cfg_pkg::line_adr_t l);
		icache_cfg_pkg::line_t v;
		for (int k = 0; k < 4; k++)
			v[k] = {l, 4'b0000} + 32'(4 * k);
		return v;
	endfunction

	function automatic icache_cfg_pkg::adr_t pick_fetch_adr(int mode);
		logic [31:0] tsel;
		case (mode)
			// Three tags on set 3 of both banks against two ways, so lines keep evicting
			MODE_CONFLICT: begin
				tsel = take_bits(2);
				if (tsel == 3)
					tsel = 0;
				return WIN_BASE + (tsel << 8) + 32'h60 + (take_bits(2) << 2);
			end
			MODE_INV: return WIN_BASE + (take_bits(6) << 2);
			default:  return WIN_BASE + (take_bits(8) << 2);
		endcase
	endfunction

	// =========================================================================
	// Reference model
	// =========================================================================

	// Line bit 0 is the parity, bits 3:1 the set and bits 27:4 the tag
	function automatic bit model_lookup(icache_cfg_pkg::line_adr_t l);
		bit found;
		found = 1'b0;
		for (int w = 0; w < icache_cfg_pkg::WAYS; w++)
			if (m_valid[l[0]][w][l[3:1]] && m_tag[l[0]][w][l[3:1]] == l[27:4])
				found = 1'b1;
		return found;
	endfunction

	task automatic model_clear();
		for (int b = 0; b < 2; b++)
			for (int w = 0; w < icache_cfg_pkg::WAYS; w++)
				for (int s = 0; s < icache_cfg_pkg::SETS; s++)
					m_valid[b][w][s] = 1'b0;
	endtask

	task automatic report_value(string what, logic [127:0] exp_val, logic [127:0] act_val);
		errors++;
		$display("** Error [%s] %s: expected %0h, actual %0h",
			cur_test, what, exp_val, act_val);
	endtask

	// Called at a falling edge, it predicts the lookup sampled at the last
	// rising edge, applies that edge to the model, then checks the outputs
	task automatic step_and_check();
		icache_cfg_pkg::line_adr_t lo_line;
		icache_cfg_pkg::line_adr_t hi_line;
		bit lo_hit;
		bit hi_hit;
		bit fill;
		lo_line = p_fetch_adr[31:4];
		hi_line = lo_line + 1'b1;
		// Lookups see the contents from before the edge
		lo_hit  = model_lookup(lo_line);
		hi_hit  = model_lookup(hi_line);
		fill    = (m_state == icache_ctl_pkg::RF_REQ) && p_ack;
		if (p_inv_op == icache_ctl_pkg::INV_ALL) begin
			model_clear();
		end else if (p_inv_op == icache_ctl_pkg::INV_LINE) begin
			for (int w = 0; w < icache_cfg_pkg::WAYS; w++)
				m_valid[p_inv_adr[4]][w][p_inv_adr[7:5]] = 1'b0;
		end
		// A write beats an invalidation at the same edge
		if (fill) begin
			m_valid[m_adr[0]][m_ptr[m_adr[0]]][m_adr[3:1]] = 1'b1;
			m_tag[m_adr[0]][m_ptr[m_adr[0]]][m_adr[3:1]]   = m_adr[27:4];
			m_ptr[m_adr[0]] = !m_ptr[m_adr[0]];
			refills++;
		end
		case (m_state)
			icache_ctl_pkg::RF_IDLE:
				if (pend_miss_v) begin
					m_state = icache_ctl_pkg::RF_REQ;
					m_adr   = pend_miss_adr;
				end
			icache_ctl_pkg::RF_REQ:
				if (p_ack)
					m_state = icache_ctl_pkg::RF_WAIT_LOW;
			default:
				if (!p_ack)
					m_state = icache_ctl_pkg::RF_IDLE;
		endcase

		if (refill_req !== (m_state == icache_ctl_pkg::RF_REQ))
			report_value("refill_req_o", m_state == icache_ctl_pkg::RF_REQ, refill_req);
		if (m_state == icache_ctl_pkg::RF_REQ && refill_adr !== m_adr)
			report_value("refill_adr_o", m_adr, refill_adr);
		if (valid !== p_fetch_v)
			report_value("valid_o", p_fetch_v, valid);
		pend_miss_v = 1'b0;
		if (!p_fetch_v) begin
			if (hit !== 1'b0)
				report_value("hit_o", 1'b0, hit);
		end else begin
			if (hit !== (lo_hit && hi_hit))
				report_value("hit_o", lo_hit && hi_hit, hit);
			if (adr !== p_fetch_adr)
				report_value("adr_o", p_fetch_adr, adr);
			if (lo_hit && hi_hit) begin
				hits++;
				if (line_lo !== line_contents(lo_line))
					report_value("line_lo_o", line_contents(lo_line), line_lo);
				if (line_hi !== line_contents(hi_line))
					report_value("line_hi_o", line_contents(hi_line), line_hi);
			end else begin
				misses++;
				// The lo line is fetched first
				pend_miss_v   = 1'b1;
				pend_miss_adr = lo_hit ? hi_line : lo_line;
			end
		end
	endtask

	// =========================================================================
	// Stimulus and responder
	// =========================================================================

	task automatic drive_inputs(int mode);
		logic [31:0] r;
		// The four-phase responder drops ack once req has been seen low
		if (refill_ack) begin
			if (!refill_req)
				refill_ack = 1'b0;
		end else if (refill_req) begin
			if (resp_wait < 0)
				resp_wait = take_bits(2);
			if (resp_wait == 0) begin
				refill_ack  = 1'b1;
				refill_data = line_contents(refill_adr);
				resp_wait   = -1;
			end else begin
				resp_wait--;
			end
		end
		fetch_v   = (mode != MODE_IDLE) && (take_bits(2) != 0);
		fetch_adr = pick_fetch_adr(mode);
		inv_op    = icache_ctl_pkg::INV_NONE;
		inv_adr   = '0;
		if (mode == MODE_INV) begin
			r = take_bits(5);
			if (r == 0) begin
				inv_op = icache_ctl_pkg::INV_ALL;
			end else if (r < 3) begin
				inv_op  = icache_ctl_pkg::INV_LINE;
				inv_adr = WIN_BASE + (take_bits(4) << 4);
			end
		end
		p_fetch_v   = fetch_v;
		p_fetch_adr = fetch_adr;
		p_inv_op    = inv_op;
		p_inv_adr   = inv_adr;
		p_ack       = refill_ack;
	endtask

	task automatic run_phase(string name, int mode);
		cur_test = name;
		repeat (PHASE_CYCLES) begin
			@(negedge clk);
			step_and_check();
			drive_inputs(mode);
		end
	endtask

	initial begin
		clk         = 1'b0;
		rst         = 1'b1;
		fetch_v     = 1'b0;
		fetch_adr   = '0;
		inv_op      = icache_ctl_pkg::INV_NONE;
		inv_adr     = '0;
		refill_ack  = 1'b0;
		refill_data = '0;
		lfsr_q      = 32'hab19;
		resp_wait   = -1;
		errors      = 0;
		hits        = 0;
		misses      = 0;
		refills     = 0;
		cycle_cnt   = 0;
		cur_test    = "reset";
		model_clear();
		m_ptr         = '{1'b0, 1'b0};
		m_state       = icache_ctl_pkg::RF_IDLE;
		m_adr         = '0;
		pend_miss_v   = 1'b0;
		pend_miss_adr = '0;
		p_fetch_v     = 1'b0;
		p_fetch_adr   = '0;
		p_inv_op      = icache_ctl_pkg::INV_NONE;
		p_inv_adr     = '0;
		p_ack         = 1'b0;

		repeat (2) @(negedge clk);
		if (valid !== 1'b0)
			report_value("valid_o", 1'b0, valid);
		if (hit !== 1'b0)
			report_value("hit_o", 1'b0, hit);
		if (refill_req !== 1'b0)
			report_value("refill_req_o", 1'b0, refill_req);
		rst = 1'b0;

		run_phase("spread", MODE_SPREAD);
		run_phase("conflict", MODE_CONFLICT);
		run_phase("invalidate", MODE_INV);

		// Let the last refill finish its exchange
		cur_test = "drain";
		while (m_state != icache_ctl_pkg::RF_IDLE || refill_ack ||
			pend_miss_v || p_fetch_v) begin
			@(negedge clk);
			step_and_check();
			drive_inputs(MODE_IDLE);
		end

		if (hits == 0) begin
			errors++;
			$display("Error [%s] no fetch ever hit the cache", cur_test);
		end
		$display("Done: %0d errors, %0d hits, %0d misses, %0d refills",
			errors, hits, misses, refills);
		if (errors == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule
